// File: rtl/xt_periph_pkg.sv
// XT peripheral glue package
// Bus widths, port base addresses, EMS write rule constants and
// the packed structs shared by the decoder, mapper and read mux

package xt_periph_pkg;

    // Bus and register widths
    typedef logic [19:0] addr_t;
    typedef logic [15:0] port_t;
    typedef logic [7:0]  data_t;
    typedef logic [6:0]  ems_page_t;
    typedef logic [1:0]  ems_slot_t;

    localparam int EMS_SLOTS = 4;

    // Default I/O bases
    localparam port_t DEFAULT_EMS_PORT = 16'h0260;
    localparam port_t DEFAULT_LPT_PORT = 16'h0378;

    // EMS page register write rule
    localparam data_t EMS_DISABLE_CODE = 8'hFF;
    localparam data_t EMS_MAP_LIMIT    = 8'h80;

    // CPU bus as seen by the glue, 31 bits
    typedef struct packed {
        addr_t address;
        data_t data;
        logic  io_read_n;
        logic  io_write_n;
        logic  address_enable_n;
    } cpu_bus_t;

    // Decoded selects, active high
    typedef struct packed {
        logic dma;
        logic pic;
        logic pit;
        logic ppi;
        logic dma_page;
        logic ems;
        logic lpt;
    } io_sel_t;

endpackage

// File: rtl/io_decoder.sv
// I/O port decoder
// Turns CPU I/O cycles into active-high selects and the
// active-low chip selects of the external legacy chips

`timescale 1ns/10ps

module io_decoder #(
    parameter xt_periph_pkg::port_t EMS_PORT = xt_periph_pkg::DEFAULT_EMS_PORT,
    parameter xt_periph_pkg::port_t LPT_PORT = xt_periph_pkg::DEFAULT_LPT_PORT
) (
    input  xt_periph_pkg::cpu_bus_t bus_i,
    input  logic                    ems_enabled_i,
    output xt_periph_pkg::io_sel_t  sel_o,
    output logic                    dma_cs_n_o,
    output logic                    pic_cs_n_o,
    output logic                    pit_cs_n_o,
    output logic                    ppi_cs_n_o,
    output logic                    dma_page_cs_n_o
);
    import xt_periph_pkg::*;

    port_t port;
    logic  io_cycle;
    logic  legacy_block;

    assign port         = bus_i.address[15:0];
    assign io_cycle     = (~bus_i.io_read_n | ~bus_i.io_write_n) & ~bus_i.address_enable_n;
    assign legacy_block = io_cycle & (port[9:8] == 2'b00);

    always_comb begin
        sel_o = '0;

        // 32-port blocks in the first 256 ports
        if (legacy_block) begin
            case (port[7:5])
                3'd0:    sel_o.dma      = 1'b1;
                3'd1:    sel_o.pic      = 1'b1;
                3'd2:    sel_o.pit      = 1'b1;
                3'd3:    sel_o.ppi      = 1'b1;
                3'd4:    sel_o.dma_page = 1'b1;
                default: ;
            endcase
        end

        // Four page registers
        sel_o.ems = io_cycle & ems_enabled_i & (port[15:2] == EMS_PORT[15:2]);

        // Eight ports, only the data latch answers
        sel_o.lpt = io_cycle & (port[15:3] == LPT_PORT[15:3]);
    end

    assign dma_cs_n_o      = ~sel_o.dma;
    assign pic_cs_n_o      = ~sel_o.pic;
    assign pit_cs_n_o      = ~sel_o.pit;
    assign ppi_cs_n_o      = ~sel_o.ppi;
    assign dma_page_cs_n_o = ~sel_o.dma_page;

endmodule

// File: rtl/ems_mapper.sv
// EMS page mapper
// Four page registers with a one-stage write pipeline, the memory
// window hit compare and the read value of the addressed slot

`timescale 1ns/10ps

module ems_mapper (
    input  logic                                 clock,
    input  logic                                 reset,
    input  xt_periph_pkg::cpu_bus_t              bus_i,
    input  xt_periph_pkg::io_sel_t               sel_i,
    input  logic [1:0]                           window_sel_i,
    output logic [xt_periph_pkg::EMS_SLOTS-1:0]  window_hit_o,
    output xt_periph_pkg::data_t                 read_data_o
);
    import xt_periph_pkg::*;

    ems_page_t             slot_page [EMS_SLOTS];
    logic [EMS_SLOTS-1:0]  slot_enable;

    // Write pipeline stage
    ems_slot_t  wr_slot;
    logic       wr_enable;
    ems_page_t  wr_page;
    logic       wr_slot_enable;

    ems_slot_t  bus_slot;
    logic       io_cycle;
    logic       write_disable;
    logic       write_map;
    logic [3:0] window_base;

    assign bus_slot      = bus_i.address[1:0];
    assign io_cycle      = (~bus_i.io_read_n | ~bus_i.io_write_n) & ~bus_i.address_enable_n;
    assign write_disable = (bus_i.data == EMS_DISABLE_CODE);
    assign write_map     = (bus_i.data < EMS_MAP_LIMIT);

    // Other codes leave the slot alone, so no write is issued
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_slot        <= '0;
            wr_enable      <= 1'b0;
            wr_page        <= '0;
            wr_slot_enable <= 1'b0;
        end else begin
            wr_slot        <= bus_slot;
            wr_enable      <= sel_i.ems & ~bus_i.io_write_n & (write_disable | write_map);
            wr_page        <= write_disable ? 7'h7F : bus_i.data[6:0];
            wr_slot_enable <= ~write_disable;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < EMS_SLOTS; i++) begin
                slot_page[i] <= '0;
            end
            slot_enable <= '0;
        end else if (wr_enable) begin
            slot_page[wr_slot]   <= wr_page;
            slot_enable[wr_slot] <= wr_slot_enable;
        end
    end

    // Window at A0000h, C0000h or D0000h
    always_comb begin
        case (window_sel_i)
            2'd0:    window_base = 4'hA;
            2'd1:    window_base = 4'hC;
            default: window_base = 4'hD;
        endcase
    end

    always_comb begin
        for (int i = 0; i < EMS_SLOTS; i++) begin
            window_hit_o[i] = ~io_cycle & slot_enable[i]
                & (bus_i.address[19:14] == {window_base, ems_slot_t'(i)});
        end
    end

    assign read_data_o = slot_enable[bus_slot] ? {1'b0, slot_page[bus_slot]} : EMS_DISABLE_CODE;

endmodule

// File: rtl/bus_read_mux.sv
// CPU read-back multiplexer
// Holds the parallel port data latch and registers the
// prioritized read byte and chipset flag onto the CPU bus

`timescale 1ns/10ps

module bus_read_mux (
    input  logic                    clock,
    input  logic                    reset,
    input  xt_periph_pkg::cpu_bus_t bus_i,
    input  xt_periph_pkg::io_sel_t  sel_i,
    input  logic                    interrupt_acknowledge_n_i,
    input  xt_periph_pkg::data_t    pic_data_i,
    input  xt_periph_pkg::data_t    pit_data_i,
    input  xt_periph_pkg::data_t    ppi_data_i,
    input  xt_periph_pkg::data_t    ems_data_i,
    output xt_periph_pkg::data_t    data_bus_out_o,
    output logic                    data_bus_out_from_chipset_o
);
    import xt_periph_pkg::*;

    data_t lpt_data;
    data_t read_next;
    logic  chipset_next;
    logic  io_read;

    assign io_read = ~bus_i.io_read_n;

    // Parallel port data latch, idles high
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data <= 8'hFF;
        end else if (sel_i.lpt & ~bus_i.io_write_n) begin
            lpt_data <= bus_i.data;
        end
    end

    // Fixed priority, interrupt vector first
    always_comb begin
        chipset_next = 1'b1;
        if (~interrupt_acknowledge_n_i) begin
            read_next = pic_data_i;
        end else if (sel_i.pic & io_read) begin
            read_next = pic_data_i;
        end else if (sel_i.pit & io_read) begin
            read_next = pit_data_i;
        end else if (sel_i.ppi & io_read) begin
            read_next = ppi_data_i;
        end else if (sel_i.ems & io_read) begin
            read_next = ems_data_i;
        end else if (sel_i.lpt & io_read) begin
            read_next = lpt_data;
        end else begin
            chipset_next = 1'b0;
            read_next    = '0;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_out_o              <= '0;
            data_bus_out_from_chipset_o <= 1'b0;
        end else begin
            data_bus_out_o              <= read_next;
            data_bus_out_from_chipset_o <= chipset_next;
        end
    end

endmodule

// File: rtl/xt_periph_top.sv
// XT peripheral I/O glue, top level
// Packs the CPU bus and connects the port decoder, the EMS
// page mapper and the read-back multiplexer

`timescale 1ns/10ps

module xt_periph_top #(
    parameter xt_periph_pkg::port_t EMS_PORT = xt_periph_pkg::DEFAULT_EMS_PORT,
    parameter xt_periph_pkg::port_t LPT_PORT = xt_periph_pkg::DEFAULT_LPT_PORT
) (
    input  logic                                clock,
    input  logic                                reset,
    input  xt_periph_pkg::addr_t                address_i,
    input  xt_periph_pkg::data_t                data_i,
    input  logic                                io_read_n_i,
    input  logic                                io_write_n_i,
    input  logic                                address_enable_n_i,
    input  logic                                interrupt_acknowledge_n_i,
    input  logic                                ems_enabled_i,
    input  logic [1:0]                          ems_window_i,
    input  xt_periph_pkg::data_t                pic_data_i,
    input  xt_periph_pkg::data_t                pit_data_i,
    input  xt_periph_pkg::data_t                ppi_data_i,
    output logic                                dma_cs_n_o,
    output logic                                pic_cs_n_o,
    output logic                                pit_cs_n_o,
    output logic                                ppi_cs_n_o,
    output logic                                dma_page_cs_n_o,
    output logic [xt_periph_pkg::EMS_SLOTS-1:0] ems_hit_o,
    output xt_periph_pkg::data_t                data_bus_out_o,
    output logic                                data_bus_out_from_chipset_o
);
    import xt_periph_pkg::*;

    cpu_bus_t bus;
    io_sel_t  sel;
    data_t    ems_data;

    assign bus.address          = address_i;
    assign bus.data             = data_i;
    assign bus.io_read_n        = io_read_n_i;
    assign bus.io_write_n       = io_write_n_i;
    assign bus.address_enable_n = address_enable_n_i;

    io_decoder #(
        .EMS_PORT (EMS_PORT),
        .LPT_PORT (LPT_PORT)
    ) u_io_decoder (
        .bus_i           (bus),
        .ems_enabled_i   (ems_enabled_i),
        .sel_o           (sel),
        .dma_cs_n_o      (dma_cs_n_o),
        .pic_cs_n_o      (pic_cs_n_o),
        .pit_cs_n_o      (pit_cs_n_o),
        .ppi_cs_n_o      (ppi_cs_n_o),
        .dma_page_cs_n_o (dma_page_cs_n_o)
    );

    ems_mapper u_ems_mapper (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus),
        .sel_i        (sel),
        .window_sel_i (ems_window_i),
        .window_hit_o (ems_hit_o),
        .read_data_o  (ems_data)
    );

    bus_read_mux u_bus_read_mux (
        .clock                       (clock),
        .reset                       (reset),
        .bus_i                       (bus),
        .sel_i                       (sel),
        .interrupt_acknowledge_n_i   (interrupt_acknowledge_n_i),
        .pic_data_i                  (pic_data_i),
        .pit_data_i                  (pit_data_i),
        .ppi_data_i                  (ppi_data_i),
        .ems_data_i                  (ems_data),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock and reset source
// Free-running clock and an active-high reset held for a fixed cycle count

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clock_o = ~clock_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b0;
    end

endmodule

// File: sim/tb_xt_periph.sv
// Testbench for the XT peripheral I/O glue
// Drives random bus cycles, runs a cycle model beside the DUT and compares

`timescale 1ns/10ps

module tb_xt_periph;
    import xt_periph_pkg::*;

    typedef struct packed {
        logic [3:0][6:0] page;
        logic [3:0]      en;
        logic [1:0]      wr_slot;
        logic            wr_en;
        logic [6:0]      wr_page;
        logic            wr_en_val;
        data_t           lpt;
        data_t           out;
        logic            flag;
    } model_t;

    logic       clock;
    logic       reset;
    addr_t      address;
    data_t      data;
    logic       io_read_n;
    logic       io_write_n;
    logic       aen_n;
    logic       inta_n;
    logic       ems_enabled;
    logic [1:0] ems_window;
    data_t      pic_data;
    data_t      pit_data;
    data_t      ppi_data;
    logic [4:0] cs_n;
    logic [3:0] hit;
    data_t      bus_out;
    logic       bus_flag;
    model_t     model;
    string      test_name;
    int         errors;

    tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(5)) u_clock_gen (
        .clock_o (clock),
        .reset_o (reset)
    );

    xt_periph_top dut (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .address_enable_n_i          (aen_n),
        .interrupt_acknowledge_n_i   (inta_n),
        .ems_enabled_i               (ems_enabled),
        .ems_window_i                (ems_window),
        .pic_data_i                  (pic_data),
        .pit_data_i                  (pit_data),
        .ppi_data_i                  (ppi_data),
        .dma_cs_n_o                  (cs_n[4]),
        .pic_cs_n_o                  (cs_n[3]),
        .pit_cs_n_o                  (cs_n[2]),
        .ppi_cs_n_o                  (cs_n[1]),
        .dma_page_cs_n_o             (cs_n[0]),
        .ems_hit_o                   (hit),
        .data_bus_out_o              (bus_out),
        .data_bus_out_from_chipset_o (bus_flag)
    );

    function automatic logic is_io(logic rd_n, logic wr_n, logic en_n);
        return (!rd_n || !wr_n) && !en_n;
    endfunction

    // Bit order dma, pic, pit, ppi, dma_page, ems, lpt
    function automatic logic [6:0] decode(addr_t a, logic io, logic ems_on);
        logic [6:0] sel;
        sel = '0;
        if (io && a[9:8] == 2'b00 && a[7:5] <= 3'd4) begin
            sel[6 - a[7:5]] = 1'b1;
        end
        sel[1] = io && ems_on && (a[15:2] == DEFAULT_EMS_PORT[15:2]);
        sel[0] = io && (a[15:3] == DEFAULT_LPT_PORT[15:3]);
        return sel;
    endfunction

    function automatic logic [3:0] window_hits(model_t s, addr_t a, logic io, logic [1:0] win);
        logic [3:0] base;
        logic [3:0] h;
        base = (win == 2'd0) ? 4'hA : (win == 2'd1) ? 4'hC : 4'hD;
        for (int i = 0; i < 4; i++) begin
            h[i] = !io && s.en[i] && (a[19:14] == {base, 2'(i)});
        end
        return h;
    endfunction

    function automatic data_t slot_value(model_t s, logic [1:0] slot);
        return s.en[slot] ? {1'b0, s.page[slot]} : 8'hFF;
    endfunction

    // One clock of the DUT, inputs as sampled at the rising edge
    function automatic model_t model_step(model_t s);
        model_t     n;
        logic [6:0] sel;
        logic       rd;
        n = s;
        sel = decode(address, is_io(io_read_n, io_write_n, aen_n), ems_enabled);
        rd = !io_read_n;
        if (s.wr_en) begin
            n.page[s.wr_slot] = s.wr_page;
            n.en[s.wr_slot] = s.wr_en_val;
        end
        n.wr_slot = address[1:0];
        n.wr_en = sel[1] && !io_write_n && (data == EMS_DISABLE_CODE || data < EMS_MAP_LIMIT);
        n.wr_page = (data == EMS_DISABLE_CODE) ? 7'h7F : data[6:0];
        n.wr_en_val = (data != EMS_DISABLE_CODE);
        if (sel[0] && !io_write_n) n.lpt = data;
        n.flag = 1'b1;
        if (!inta_n) n.out = pic_data;
        else if (sel[5] && rd) n.out = pic_data;
        else if (sel[4] && rd) n.out = pit_data;
        else if (sel[3] && rd) n.out = ppi_data;
        else if (sel[1] && rd) n.out = slot_value(s, address[1:0]);
        else if (sel[0] && rd) n.out = s.lpt;
        else begin
            n.flag = 1'b0;
            n.out = '0;
        end
        return n;
    endfunction

    task automatic check(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Mismatch test=%s %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            $display("TB FAILED");
            $fatal(1, "Output differs from the model");
        end
    endtask

    task automatic stop_run(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Run aborted");
    endtask

    // Compare after the edge has settled, inputs stay put until the falling edge
    always @(posedge clock) begin
        logic       io;
        logic [6:0] sel;
        logic [4:0] cs_expected;
        #1;
        if (reset) begin
            model = '0;
            model.lpt = 8'hFF;
        end else begin
            model = model_step(model);
            io = is_io(io_read_n, io_write_n, aen_n);
            sel = decode(address, io, ems_enabled);
            cs_expected = ~sel[6:2];
            check("chip selects", 32'(cs_expected), 32'(cs_n));
            check("window hits", 32'(window_hits(model, address, io, ems_window)), 32'(hit));
            check("read data", 32'(model.out), 32'(bus_out));
            check("chipset flag", 32'(model.flag), 32'(bus_flag));
        end
    end

    task automatic bus_cycle(addr_t a, data_t d, logic rd_n, logic wr_n, logic en_n);
        @(negedge clock);
        address = a;
        data = d;
        io_read_n = rd_n;
        io_write_n = wr_n;
        aen_n = en_n;
        pic_data = 8'($urandom);
        pit_data = 8'($urandom);
        ppi_data = 8'($urandom);
    endtask

    task automatic io_write(addr_t a, data_t d);
        bus_cycle(a, d, 1'b1, 1'b0, 1'b0);
        bus_cycle(20'($urandom), 8'($urandom), 1'b1, 1'b1, 1'b1);
    endtask

    task automatic io_read(addr_t a);
        bus_cycle(a, 8'($urandom), 1'b0, 1'b1, 1'b0);
        bus_cycle(20'($urandom), 8'($urandom), 1'b1, 1'b1, 1'b1);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (reset && n < 100) begin
            @(negedge clock);
            n++;
        end
        if (reset) stop_run("Reset was never released");
    endtask

    initial begin : watchdog
        int n;
        n = 0;
        while (n < 20000) begin
            @(posedge clock);
            n++;
        end
        stop_run("Run did not finish within 20000 cycles");
    end

    initial begin
        addr_t   a;
        data_t   values[6];
        logic [3:0] base;
        void'($urandom(21991));
        errors = 0;
        test_name = "reset";
        address = '0;
        data = '0;
        io_read_n = 1'b1;
        io_write_n = 1'b1;
        aen_n = 1'b1;
        inta_n = 1'b1;
        ems_enabled = 1'b1;
        ems_window = 2'd0;
        pic_data = '0;
        pit_data = '0;
        ppi_data = '0;
        wait_reset_release();

        for (int s = 0; s < 4; s++) io_read(addr_t'(20'h260 + s));
        io_read(20'h378);

        test_name = "chip selects";
        repeat (300) begin
            bus_cycle(20'($urandom_range(0, 'h3FF)), 8'($urandom), 1'($urandom),
                      1'b1, 1'($urandom));
        end

        test_name = "ems";
        for (int s = 0; s < 4; s++) begin
            values = '{8'hFF, 8'($urandom_range(0, 'h7F)), 8'($urandom_range('h80, 'hFE)),
                       8'h00, 8'h7F, 8'h80};
            foreach (values[k]) begin
                io_write(addr_t'(20'h260 + s), values[k]);
                io_read(addr_t'(20'h260 + s));
            end
            // Read right behind the write still sees the old page
            bus_cycle(addr_t'(20'h260 + s), 8'($urandom_range(0, 'h7F)), 1'b1, 1'b0, 1'b0);
            io_read(addr_t'(20'h260 + s));
        end

        // Four writes in flight one cycle apart
        for (int s = 0; s < 4; s++) begin
            bus_cycle(addr_t'(20'h260 + s), 8'($urandom_range(0, 'h7F)), 1'b1, 1'b0, 1'b0);
        end
        for (int s = 0; s < 4; s++) io_read(addr_t'(20'h260 + s));

        ems_enabled = 1'b0;
        io_write(20'h261, 8'h12);
        io_read(20'h261);
        io_read(20'h262);
        ems_enabled = 1'b1;
        io_read(20'h261);

        test_name = "window hits";
        for (int w = 0; w < 4; w++) begin
            ems_window = 2'(w);
            base = (w == 0) ? 4'hA : (w == 1) ? 4'hC : 4'hD;
            io_write(addr_t'(20'h260 + $urandom_range(0, 3)), 8'($urandom));
            repeat (60) begin
                a = 20'($urandom);
                if ($urandom_range(0, 1) == 1) a[19:14] = {base, 2'($urandom)};
                bus_cycle(a, 8'($urandom), 1'($urandom), 1'($urandom), 1'b1);
                a[19:16] = base;
                bus_cycle(a, 8'($urandom), 1'b0, 1'b1, 1'b0);
            end
        end

        test_name = "parallel port";
        repeat (10) begin
            io_write(addr_t'(20'h378 + $urandom_range(0, 7)), 8'($urandom));
            io_read(addr_t'(20'h378 + $urandom_range(0, 7)));
        end

        test_name = "read priority";
        repeat (300) begin
            case ($urandom_range(0, 5))
                0: a = addr_t'(20'h20 + $urandom_range(0, 31));
                1: a = addr_t'(20'h40 + $urandom_range(0, 31));
                2: a = addr_t'(20'h60 + $urandom_range(0, 31));
                3: a = addr_t'(20'h260 + $urandom_range(0, 3));
                4: a = addr_t'(20'h378 + $urandom_range(0, 7));
                default: a = 20'($urandom);
            endcase
            inta_n = ($urandom_range(0, 3) != 0);
            bus_cycle(a, 8'($urandom), 1'($urandom), 1'b1, 1'($urandom_range(0, 3) == 0));
        end
        inta_n = 1'b1;
        repeat (4) bus_cycle(20'($urandom), 8'($urandom), 1'b1, 1'b1, 1'b1);

        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
rtl/xt_periph_pkg.sv
rtl/io_decoder.sv
rtl/ems_mapper.sv
rtl/bus_read_mux.sv
rtl/xt_periph_top.sv
sim/tb_clock_gen.sv
sim/tb_xt_periph.sv

// File: Makefile
# Verilator build for the XT peripheral glue

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_xt_periph
RTL_TOP   ?= xt_periph_top
FILELIST  ?= all.f
PASS_MSG  := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
